/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module egress_tb -f vlog.f -Mdir obj_dir
	./obj_dir/Vegress_tb | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* logic/egress_demux.sv */
////////////////////////////////////////////////////////////
// Registered demux from the egress bus to per-port writes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module egress_demux
    import egress_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 egr_bus,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  egr_beat_t            in_beat,
    output logic [NUM_PORTS-1:0] port_wr_valid,
    output buf_entry_t           wr_entry
);

    // One-hot decode, out-of-range ports match nothing
    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            port_wr_valid <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_wr_valid[p] <= in_valid && (in_beat.port == PORT_IDX_W'(p));
            end
        end
    end

    // Shared payload for all buffers
    always_ff @(posedge egr_bus) begin
        wr_entry.data <= in_beat.data;
        wr_entry.keep <= in_beat.keep;
        wr_entry.last <= in_beat.last;
    end

    // At most one port written, and only for a beat offered the cycle before
    assert property (@(posedge egr_bus) disable iff (!rst_n)
        port_wr_valid != '0 |-> $onehot(port_wr_valid) && $past(in_valid));

endmodule

/* logic/egress_pkg.sv */
////////////////////////////////////////////////////////////
// Egress stage widths, beat and counter structs, FSM enums
////////////////////////////////////////////////////////////

package egress_pkg;

    // Bus and port widths in bytes
    localparam int BUS_BYTES  = 8;
    localparam int PHYS_BYTES = 2;
    localparam int PORT_IDX_W = 4;
    localparam int CNT_WIDTH  = 32;

    ////////////////////////////////////////////////////////////
    // Beats

    typedef struct packed {
        logic [BUS_BYTES*8-1:0] data;
        logic [BUS_BYTES-1:0]   keep;
        logic                   last;
        logic [PORT_IDX_W-1:0]  port;
    } egr_beat_t;

    // Egress port number is dropped once the beat is steered
    typedef struct packed {
        logic [BUS_BYTES*8-1:0] data;
        logic [BUS_BYTES-1:0]   keep;
        logic                   last;
    } buf_entry_t;

    typedef struct packed {
        logic [PHYS_BYTES*8-1:0] data;
        logic [PHYS_BYTES-1:0]   keep;
        logic                    last;
    } port_beat_t;

    ////////////////////////////////////////////////////////////
    // Counters and states

    typedef struct packed {
        logic [CNT_WIDTH-1:0] pkts_sent;
        logic [CNT_WIDTH-1:0] bytes_sent;
        logic [CNT_WIDTH-1:0] pkts_dropped;
    } port_cnts_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCEPT,
        DISCARD
    } admit_state_t;

    typedef enum logic {
        EMPTY,
        SPLIT
    } split_state_t;

endpackage

/* logic/p4_egress_top.sv */
////////////////////////////////////////////////////////////
// Egress top: demux, then per-port buffer, downsizer and
// counters
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module p4_egress_top
    import egress_pkg::*;
#(
    parameter int NUM_PORTS     = 4,
    parameter int FIFO_DEPTH    = 32,
    parameter int MAX_PKT_BEATS = 8
) (
    input  logic                 egr_bus,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  egr_beat_t            in_beat,
    input  logic [NUM_PORTS-1:0] port_enable,
    input  logic [NUM_PORTS-1:0] cnts_clear,
    input  logic [NUM_PORTS-1:0] phys_ready,
    output logic [NUM_PORTS-1:0] buf_ready,
    output logic [NUM_PORTS-1:0] phys_valid,
    output port_beat_t           phys_beat [NUM_PORTS],
    output port_cnts_t           cnts [NUM_PORTS],
    output logic [NUM_PORTS-1:0] buf_full_drop
);

    logic [NUM_PORTS-1:0] port_wr_valid;
    buf_entry_t           wr_entry;
    logic [NUM_PORTS-1:0] buf_rd_valid;
    logic [NUM_PORTS-1:0] buf_rd_ready;
    buf_entry_t           buf_rd_entry [NUM_PORTS];

    egress_demux #(
        .NUM_PORTS     ( NUM_PORTS     )
    ) demux0 (
        .egr_bus       ( egr_bus       ),
        .rst_n         ( rst_n         ),
        .in_valid      ( in_valid      ),
        .in_beat       ( in_beat       ),
        .port_wr_valid ( port_wr_valid ),
        .wr_entry      ( wr_entry      )
    );

    ////////////////////////////////////////////////////////////
    // Per-port path

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port

        port_buffer #(
            .FIFO_DEPTH    ( FIFO_DEPTH       ),
            .MAX_PKT_BEATS ( MAX_PKT_BEATS    )
        ) buf0 (
            .egr_bus       ( egr_bus          ),
            .rst_n         ( rst_n            ),
            .wr_valid      ( port_wr_valid[p] ),
            .wr_entry      ( wr_entry         ),
            .port_enable   ( port_enable[p]   ),
            .rd_ready      ( buf_rd_ready[p]  ),
            .rd_valid      ( buf_rd_valid[p]  ),
            .rd_entry      ( buf_rd_entry[p]  ),
            .buf_ready     ( buf_ready[p]     ),
            .drop_pulse    ( buf_full_drop[p] )
        );

        width_downsizer dsz0 (
            .egr_bus       ( egr_bus          ),
            .rst_n         ( rst_n            ),
            .in_valid      ( buf_rd_valid[p]  ),
            .in_entry      ( buf_rd_entry[p]  ),
            .out_ready     ( phys_ready[p]    ),
            .in_ready      ( buf_rd_ready[p]  ),
            .out_valid     ( phys_valid[p]    ),
            .out_beat      ( phys_beat[p]     )
        );

        port_counters cnt0 (
            .egr_bus       ( egr_bus          ),
            .rst_n         ( rst_n            ),
            .clear         ( cnts_clear[p]    ),
            .tx_valid      ( phys_valid[p]    ),
            .tx_ready      ( phys_ready[p]    ),
            .tx_beat       ( phys_beat[p]     ),
            .drop_pulse    ( buf_full_drop[p] ),
            .cnts          ( cnts[p]          )
        );

    end

endmodule

/* logic/port_buffer.sv */
////////////////////////////////////////////////////////////
// Per-port packet FIFO with admit or drop on packet start
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module port_buffer
    import egress_pkg::*;
#(
    parameter int FIFO_DEPTH    = 32,
    parameter int MAX_PKT_BEATS = 8
) (
    input  logic       egr_bus,
    input  logic       rst_n,
    input  logic       wr_valid,
    input  buf_entry_t wr_entry,
    input  logic       port_enable,
    input  logic       rd_ready,
    output logic       rd_valid,
    output buf_entry_t rd_entry,
    output logic       buf_ready,
    output logic       drop_pulse
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    buf_entry_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] free_cnt;
    logic          full;
    logic          admit;
    logic          do_write;
    logic          do_read;
    logic          start_drop;
    admit_state_t  state;
    admit_state_t  state_nxt;

    // Wraps at FIFO_DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        if (ptr == AW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Occupancy

    assign free_cnt  = CW'(FIFO_DEPTH) - count;
    assign full      = (count == CW'(FIFO_DEPTH));
    assign buf_ready = (free_cnt >= CW'(MAX_PKT_BEATS));
    assign rd_valid  = (count != '0);
    assign rd_entry  = mem[rd_ptr];
    assign do_read   = rd_valid && rd_ready;

    ////////////////////////////////////////////////////////////
    // Admit FSM

    // Room for a maximum length packet is reserved at its first beat
    assign admit = port_enable && buf_ready;

    always_comb begin
        state_nxt  = state;
        do_write   = 1'b0;
        start_drop = 1'b0;
        if (wr_valid) begin
            unique case (state)
                IDLE: begin
                    if (admit) begin
                        do_write = 1'b1;
                        if (!wr_entry.last) begin
                            state_nxt = ACCEPT;
                        end
                    end else begin
                        start_drop = 1'b1;
                        if (!wr_entry.last) begin
                            state_nxt = DISCARD;
                        end
                    end
                end
                ACCEPT: begin
                    do_write = 1'b1;
                    if (wr_entry.last) begin
                        state_nxt = IDLE;
                    end
                end
                DISCARD: begin
                    if (wr_entry.last) begin
                        state_nxt = IDLE;
                    end
                end
                default: state_nxt = IDLE;
            endcase
        end
    end

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            drop_pulse <= 1'b0;
        end else begin
            state      <= state_nxt;
            drop_pulse <= start_drop;
            if (do_write) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CW'(do_write) - CW'(do_read);
        end
    end

    always_ff @(posedge egr_bus) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // Holds only while upstream packets stay within MAX_PKT_BEATS
    assert property (@(posedge egr_bus) disable iff (!rst_n) do_write |-> !full);

endmodule

/* logic/port_counters.sv */
////////////////////////////////////////////////////////////
// Per-port sent packet, sent byte and drop counters
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module port_counters
    import egress_pkg::*;
(
    input  logic       egr_bus,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       tx_valid,
    input  logic       tx_ready,
    input  port_beat_t tx_beat,
    input  logic       drop_pulse,
    output port_cnts_t cnts
);

    logic                 tx_xfer;
    logic [CNT_WIDTH-1:0] beat_bytes;

    assign tx_xfer    = tx_valid && tx_ready;
    assign beat_bytes = CNT_WIDTH'($countones(tx_beat.keep));

    // Clear wins over any count in the same cycle
    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            cnts <= '0;
        end else if (clear) begin
            cnts <= '0;
        end else begin
            if (tx_xfer) begin
                cnts.bytes_sent <= cnts.bytes_sent + beat_bytes;
                if (tx_beat.last) begin
                    cnts.pkts_sent <= cnts.pkts_sent + 1'b1;
                end
            end
            if (drop_pulse) begin
                cnts.pkts_dropped <= cnts.pkts_dropped + 1'b1;
            end
        end
    end

endmodule

/* logic/width_downsizer.sv */
////////////////////////////////////////////////////////////
// Wide to narrow beat splitter, drops trailing null bytes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module width_downsizer
    import egress_pkg::*;
(
    input  logic       egr_bus,
    input  logic       rst_n,
    input  logic       in_valid,
    input  buf_entry_t in_entry,
    input  logic       out_ready,
    output logic       in_ready,
    output logic       out_valid,
    output port_beat_t out_beat
);

    localparam int NUM_SLICES = BUS_BYTES / PHYS_BYTES;
    localparam int SW         = $clog2(NUM_SLICES);

    split_state_t  state;
    buf_entry_t    held;
    logic [SW-1:0] slice;
    logic          last_slice;
    logic          out_xfer;
    logic          load;

    assign out_valid = (state == SPLIT);
    assign out_xfer  = out_valid && out_ready;

    // Keep is contiguous, so an unkept first byte ends the beat
    always_comb begin
        last_slice = 1'b1;
        if (slice != SW'(NUM_SLICES - 1)) begin
            last_slice = !held.keep[(slice + 1) * PHYS_BYTES];
        end
    end

    // Reload on the cycle the final slice leaves
    assign in_ready = (state == EMPTY) || (out_xfer && last_slice);
    assign load     = in_valid && in_ready;

    always_comb begin
        out_beat.data = held.data[slice*PHYS_BYTES*8 +: PHYS_BYTES*8];
        out_beat.keep = held.keep[slice*PHYS_BYTES +: PHYS_BYTES];
        out_beat.last = held.last && last_slice;
    end

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            state <= EMPTY;
            slice <= '0;
        end else if (load) begin
            state <= SPLIT;
            slice <= '0;
        end else if (out_xfer) begin
            if (last_slice) begin
                state <= EMPTY;
            end else begin
                slice <= slice + 1'b1;
            end
        end
    end

    always_ff @(posedge egr_bus) begin
        if (load) begin
            held <= in_entry;
        end
    end

    // Every stored beat has byte 0 kept and no holes in its mask
    assert property (@(posedge egr_bus) disable iff (!rst_n)
        load |-> in_entry.keep[0] && ((in_entry.keep & (in_entry.keep + 1'b1)) == '0));

endmodule

/* verif/egress_tb_model.svh */
////////////////////////////////////////////////////////////
// Reference model: expected narrow beats, occupancy, counters
////////////////////////////////////////////////////////////

`ifndef EGRESS_TB_MODEL_SVH
`define EGRESS_TB_MODEL_SVH

port_beat_t  exp_q [NUM_PORTS][$];
int unsigned exp_pkts [NUM_PORTS];
int unsigned exp_bytes [NUM_PORTS];
int unsigned exp_drops [NUM_PORTS];
// Admitted beats while the phys port is stalled
int          stored_beats [NUM_PORTS];

// Wide beat to narrow beats, bytes past the valid count never go out
function automatic void expect_wide_beat(input int p, input logic [BUS_BYTES*8-1:0] data,
                                         input int nbytes, input logic last);
    port_beat_t nb;
    int         n;
    n = (nbytes + PHYS_BYTES - 1) / PHYS_BYTES;
    for (int i = 0; i < n; i++) begin
        nb.data = data[i*PHYS_BYTES*8 +: PHYS_BYTES*8];
        for (int b = 0; b < PHYS_BYTES; b++) begin
            nb.keep[b] = (i * PHYS_BYTES + b < nbytes);
        end
        nb.last = last && (i == n - 1);
        exp_q[p].push_back(nb);
    end
    exp_bytes[p] += nbytes;
    if (last) begin
        exp_pkts[p]++;
    end
endfunction

// Free FIFO entries, one admitted beat sits in the downsizer
function automatic int model_free(input int p);
    if (stored_beats[p] == 0) begin
        return FIFO_DEPTH;
    end
    return FIFO_DEPTH - (stored_beats[p] - 1);
endfunction

`endif

/* verif/egress_tb.sv */
////////////////////////////////////////////////////////////
// Egress stage testbench with stimulus, compare and watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module egress_tb
    import egress_pkg::*;
();

    localparam int    NUM_PORTS     = 4;
    localparam int    FIFO_DEPTH    = 32;
    localparam int    MAX_PKT_BEATS = 8;
    localparam int    TOTAL_PKTS    = 60;
    localparam int    CYC_PER_BEAT  = 20;
    localparam longint TIMEOUT_NS   = TOTAL_PKTS * MAX_PKT_BEATS * CYC_PER_BEAT * 20;

    logic                 egr_bus;
    logic                 rst_n;
    logic                 in_valid;
    egr_beat_t            in_beat;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] cnts_clear;
    logic [NUM_PORTS-1:0] phys_ready;
    logic [NUM_PORTS-1:0] buf_ready;
    logic [NUM_PORTS-1:0] phys_valid;
    port_beat_t           phys_beat [NUM_PORTS];
    port_cnts_t           cnts [NUM_PORTS];
    logic [NUM_PORTS-1:0] buf_full_drop;

    int                   seed = 19519;
    logic [NUM_PORTS-1:0] ready_fixed;
    logic                 ready_rand;
    int                   cmp_errors;
    int                   cmp_count;
    int                   chk_errors;
    int                   chk_count;
    int                   errs_at_start;
    int                   drop_seen [NUM_PORTS];

    `include "egress_tb_model.svh"

    p4_egress_top #(
        .NUM_PORTS     ( NUM_PORTS     ),
        .FIFO_DEPTH    ( FIFO_DEPTH    ),
        .MAX_PKT_BEATS ( MAX_PKT_BEATS )
    ) dut0 (
        .egr_bus       ( egr_bus       ),
        .rst_n         ( rst_n         ),
        .in_valid      ( in_valid      ),
        .in_beat       ( in_beat       ),
        .port_enable   ( port_enable   ),
        .cnts_clear    ( cnts_clear    ),
        .phys_ready    ( phys_ready    ),
        .buf_ready     ( buf_ready     ),
        .phys_valid    ( phys_valid    ),
        .phys_beat     ( phys_beat     ),
        .cnts          ( cnts          ),
        .buf_full_drop ( buf_full_drop )
    );

    initial begin
        egr_bus = 1'b0;
        forever #10 egr_bus = ~egr_bus;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Phys side ready held fixed or drawn at random per port
    initial begin
        phys_ready = '1;
        forever begin
            @(negedge egr_bus);
            if (ready_rand) begin
                phys_ready = NUM_PORTS'($random(seed));
            end else begin
                phys_ready = ready_fixed;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare

    always @(posedge egr_bus) begin : compare
        port_beat_t exp_beat;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (buf_full_drop[p]) begin
                    drop_seen[p]++;
                end
                if (phys_valid[p] && phys_ready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("Port %0d sent a beat that no admitted packet explains", p);
                        cmp_errors++;
                    end else begin
                        exp_beat = exp_q[p].pop_front();
                        cmp_count++;
                        if (phys_beat[p] !== exp_beat) begin
                            $display("ERROR phys_beat[%0d] got %h expected %h",
                                     p, phys_beat[p], exp_beat);
                            cmp_errors++;
                        end
                    end
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_count++;
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            chk_errors++;
        end
    endtask

    task automatic report_test(input string name);
        int now_errors;
        now_errors = cmp_errors + chk_errors;
        $display("%s finished with %0d errors", name, now_errors - errs_at_start);
        errs_at_start = now_errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus

    task automatic send_pkt(input int p, input int nbeats, input int last_bytes,
                            input bit admit);
        egr_beat_t b;
        for (int i = 0; i < nbeats; i++) begin
            @(negedge egr_bus);
            b.data = {$random(seed), $random(seed)};
            b.last = (i == nbeats - 1);
            b.keep = b.last ? BUS_BYTES'((1 << last_bytes) - 1) : '1;
            b.port = PORT_IDX_W'(p);
            in_valid = 1'b1;
            in_beat  = b;
            if (admit) begin
                expect_wide_beat(p, b.data, b.last ? last_bytes : BUS_BYTES, b.last);
            end
        end
        if (admit) begin
            stored_beats[p] += nbeats;
        end else begin
            exp_drops[p]++;
        end
        @(negedge egr_bus);
        in_valid = 1'b0;
    endtask

    // One more cycle lets the previous last beat reach the buffer
    task automatic wait_room(input int p);
        @(negedge egr_bus);
        while (!buf_ready[p]) begin
            @(negedge egr_bus);
        end
    endtask

    task automatic send_random(input int n_pkts);
        int p;
        int nb;
        int lb;
        for (int k = 0; k < n_pkts; k++) begin
            p  = {$random(seed)} % NUM_PORTS;
            nb = 1 + {$random(seed)} % MAX_PKT_BEATS;
            lb = 1 + {$random(seed)} % BUS_BYTES;
            wait_room(p);
            send_pkt(p, nb, lb, 1'b1);
        end
    endtask

    task automatic drain();
        int pending;
        do begin
            @(negedge egr_bus);
            pending = 0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                pending += exp_q[p].size();
            end
        end while (pending != 0);
        repeat (4) @(negedge egr_bus);
    endtask

    task automatic check_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_val($sformatf("cnts[%0d].pkts_sent", p), cnts[p].pkts_sent, exp_pkts[p]);
            check_val($sformatf("cnts[%0d].bytes_sent", p), cnts[p].bytes_sent, exp_bytes[p]);
            check_val($sformatf("cnts[%0d].pkts_dropped", p), cnts[p].pkts_dropped,
                      exp_drops[p]);
        end
    endtask

    initial begin
        bit admit;
        in_valid    = 1'b0;
        in_beat     = '0;
        port_enable = '1;
        cnts_clear  = '0;
        ready_fixed = '1;
        ready_rand  = 1'b0;
        rst_n       = 1'b0;
        repeat (2) @(posedge egr_bus);
        @(negedge egr_bus);
        rst_n = 1'b1;
        check_val("buf_ready", buf_ready, {NUM_PORTS{1'b1}});
        check_val("phys_valid", phys_valid, '0);

        send_random(20);
        drain();
        report_test("Routing");

        for (int n = 1; n <= BUS_BYTES; n++) begin
            wait_room(0);
            send_pkt(0, 2, n, 1'b1);
        end
        drain();
        report_test("Narrowing");

        ready_rand = 1'b1;
        send_random(20);
        drain();
        ready_rand = 1'b0;
        report_test("Back-pressure");

        // Port 2 stalled until its FIFO refuses a packet
        ready_fixed[2]  = 1'b0;
        stored_beats[2] = 0;
        repeat (2) @(negedge egr_bus);
        for (int k = 0; k < 6; k++) begin
            admit = (model_free(2) >= MAX_PKT_BEATS);
            send_pkt(2, MAX_PKT_BEATS, BUS_BYTES, admit);
            repeat (3) @(negedge egr_bus);
            check_val("buf_ready[2]", buf_ready[2], model_free(2) >= MAX_PKT_BEATS);
        end
        check_val("buf_full_drop[2] pulse count", drop_seen[2], exp_drops[2]);
        check_val("cnts[2].pkts_dropped", cnts[2].pkts_dropped, exp_drops[2]);
        ready_fixed[2] = 1'b1;
        drain();
        report_test("Overflow drop");

        port_enable[3] = 1'b0;
        for (int k = 0; k < 3; k++) begin
            send_pkt(3, 3, 5, 1'b0);
        end
        repeat (4) @(negedge egr_bus);
        check_val("buf_full_drop[3] pulse count", drop_seen[3], exp_drops[3]);
        check_val("cnts[3].pkts_dropped", cnts[3].pkts_dropped, exp_drops[3]);
        port_enable[3] = 1'b1;
        drain();
        report_test("Disabled port");

        check_counters();
        @(negedge egr_bus);
        cnts_clear[1] = 1'b1;
        @(negedge egr_bus);
        cnts_clear[1] = 1'b0;
        exp_pkts[1]   = 0;
        exp_bytes[1]  = 0;
        exp_drops[1]  = 0;
        check_counters();
        report_test("Counters and clear");

        $display("Beats compared %0d, checks %0d, errors %0d",
                 cmp_count, chk_count, cmp_errors + chk_errors);
        if (cmp_errors + chk_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verif
logic/egress_pkg.sv
logic/egress_demux.sv
logic/port_buffer.sv
logic/width_downsizer.sv
logic/port_counters.sv
logic/p4_egress_top.sv
verif/egress_tb.sv
